// ==== com_cc_pkg.sv ====
package com_cc_pkg;

    // link geometry
    localparam int LANES          = 4;
    localparam int SYMBOL_CYCLES  = 4;
    localparam int SYNC_STAGES    = 2;
    localparam int TX_QUEUE_DEPTH = 8;

    // derived widths
    localparam int WIN_W    = $clog2(SYMBOL_CYCLES);
    localparam int TX_PTR_W = $clog2(TX_QUEUE_DEPTH);
    localparam int TX_CNT_W = TX_PTR_W + 1;

    // one symbol, one bit per lane
    typedef logic [LANES-1:0] nibble_t;

    typedef enum logic [2:0] {
        SYM_IDLE = 3'd0,
        SYM_W0   = 3'd1,
        SYM_W1   = 3'd2,
        SYM_W2   = 3'd3,
        SYM_W3   = 3'd4
    } sym_phase_e;

    // received byte, first marks the opening byte of a burst
    typedef struct packed {
        logic [7:0] data;
        logic       first;
    } rx_byte_t;

    // pin bundle, send level plus the lane toggles
    typedef struct packed {
        logic    send;
        nibble_t txd;
    } lane_bus_t;

endpackage

// ==== com_cc_tx_queue.sv ====
`timescale 1ns/1ps

module com_cc_tx_queue
    import com_cc_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       wr,
    input  logic [7:0] wr_data,
    output logic       full,
    input  logic       slot_take,
    output logic       fire,
    output nibble_t    nibble
);

    logic [7:0]          mem [TX_QUEUE_DEPTH];
    logic [TX_PTR_W-1:0] wr_ptr;
    logic [TX_PTR_W-1:0] rd_ptr;
    logic [TX_CNT_W-1:0] count;
    logic                half;
    logic [WIN_W-1:0]    tail_cnt;
    logic [7:0]          head_byte;
    logic                push;
    logic                pop;

    assign full = (count == TX_CNT_W'(TX_QUEUE_DEPTH));
    assign push = wr && !full;
    // a byte leaves only once its high nibble is taken
    assign pop  = slot_take && half;

    assign head_byte = mem[rd_ptr];
    assign nibble    = half ? head_byte[7:4] : head_byte[3:0];

    // fire stays up through the last symbol so it goes out whole
    assign fire = (count != '0) || (tail_cnt != '0);

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            half     <= 1'b0;
            tail_cnt <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (slot_take) begin
                half <= ~half;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // queue drains, remaining cycles of the high nibble symbol
            if (pop && !push && count == TX_CNT_W'(1)) begin
                tail_cnt <= WIN_W'(SYMBOL_CYCLES - 1);
            end else if (tail_cnt != '0) begin
                tail_cnt <= tail_cnt - 1'b1;
            end
        end
    end

    // the sequencer only takes nibbles inside a burst
    assert property (@(posedge clk) disable iff (rst) slot_take |-> fire)
        else $error("slot_take while fire is low");

endmodule

// ==== com_cc_tx.sv ====
`timescale 1ns/1ps

module com_cc_tx
    import com_cc_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      fire,
    input  nibble_t   nibble,
    output logic      slot_take,
    output lane_bus_t tx_pins
);

    sym_phase_e state;
    sym_phase_e state_nxt;
    lane_bus_t  core;
    lane_bus_t  stage0;

    assign slot_take = fire && (state == SYM_W0);

    always_comb begin
        if (!fire) begin
            state_nxt = SYM_IDLE;
        end else begin
            case (state)
                SYM_IDLE: state_nxt = SYM_W0;
                SYM_W0:   state_nxt = SYM_W1;
                SYM_W1:   state_nxt = SYM_W2;
                SYM_W2:   state_nxt = SYM_W3;
                SYM_W3:   state_nxt = SYM_W0;
                default:  state_nxt = SYM_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= SYM_IDLE;
            core    <= '0;
            stage0  <= '0;
            tx_pins <= '0;
        end else begin
            state <= state_nxt;
            if (!fire || state == SYM_IDLE) begin
                core <= '0;
            end else begin
                core.send <= 1'b1;
                // a set bit toggles its lane at symbol start, a clear bit holds
                if (state == SYM_W0) begin
                    for (int i = 0; i < LANES; i++) begin
                        if (nibble[i]) begin
                            core.txd[i] <= ~core.txd[i];
                        end
                    end
                end
            end
            // two pin stages, send and lanes stay aligned
            stage0  <= core;
            tx_pins <= stage0;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        state == SYM_IDLE |=> state inside {SYM_IDLE, SYM_W0})
        else $error("sequencer left idle to a state other than W0");

endmodule

// ==== com_cc_rx.sv ====
`timescale 1ns/1ps

module com_cc_rx
    import com_cc_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  lane_bus_t rx_pins,
    output logic      nib_valid,
    output nibble_t   nib,
    output logic      burst_start
);

    lane_bus_t        sync_q [SYNC_STAGES];
    lane_bus_t        synced;
    lane_bus_t        prev_q;
    nibble_t          tgl;
    nibble_t          acc;
    logic             send_rise;
    logic             win_first;
    logic             win_last;
    logic [WIN_W-1:0] win_cnt;

    assign synced    = sync_q[SYNC_STAGES-1];
    assign send_rise = synced.send && !prev_q.send;
    assign win_first = (win_cnt == '0);
    assign win_last  = synced.send && (win_cnt == WIN_W'(SYMBOL_CYCLES - 1));

    // each lane compared against its own previous sample
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            tgl[i] = synced.txd[i] ^ prev_q.txd[i];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < SYNC_STAGES; s++) begin
                sync_q[s] <= '0;
            end
            prev_q      <= '0;
            win_cnt     <= '0;
            nib_valid   <= 1'b0;
            burst_start <= 1'b0;
        end else begin
            sync_q[0] <= rx_pins;
            for (int s = 1; s < SYNC_STAGES; s++) begin
                sync_q[s] <= sync_q[s-1];
            end
            prev_q      <= synced;
            burst_start <= send_rise;
            nib_valid   <= win_last;
            // held at zero while send is low, so each window opens on the send edge
            if (!synced.send) begin
                win_cnt <= '0;
            end else begin
                win_cnt <= win_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (win_first) begin
            acc <= tgl;
        end else begin
            acc <= acc | tgl;
        end
        if (win_last) begin
            nib <= acc | tgl;
        end
    end

    // a nibble needs send high across its whole window
    assert property (@(posedge clk) disable iff (rst)
        nib_valid |-> $past(synced.send) && $past(synced.send, SYMBOL_CYCLES))
        else $error("nibble strobed outside a full send window");

endmodule

// ==== com_cc_rx_pair.sv ====
`timescale 1ns/1ps

module com_cc_rx_pair
    import com_cc_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     nib_valid,
    input  nibble_t  nib,
    input  logic     burst_start,
    output logic     rx_valid,
    output rx_byte_t rx_byte
);

    nibble_t lo_nib;
    logic    half;
    logic    first_armed;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            half        <= 1'b0;
            first_armed <= 1'b0;
            rx_valid    <= 1'b0;
        end else begin
            rx_valid <= nib_valid && half;
            if (burst_start) begin
                // new burst, any odd nibble from before is dropped
                half        <= 1'b0;
                first_armed <= 1'b1;
            end else if (nib_valid) begin
                half <= ~half;
                if (half) begin
                    first_armed <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (nib_valid && !half) begin
            lo_nib <= nib;
        end
        if (nib_valid && half) begin
            rx_byte.data  <= {nib, lo_nib};
            rx_byte.first <= first_armed;
        end
    end

endmodule

// ==== com_cc_link.sv ====
`timescale 1ns/1ps

module com_cc_link
    import com_cc_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       wr,
    input  logic [7:0] wr_data,
    output logic       full,
    output lane_bus_t  tx_pins,
    input  lane_bus_t  rx_pins,
    output logic       rx_valid,
    output rx_byte_t   rx_byte
);

    logic    fire;
    logic    slot_take;
    nibble_t tx_nibble;
    logic    nib_valid;
    nibble_t rx_nib;
    logic    burst_start;

    // transmit side
    com_cc_tx_queue u_tx_queue (
        .clk       (clk),
        .rst       (rst),
        .wr        (wr),
        .wr_data   (wr_data),
        .full      (full),
        .slot_take (slot_take),
        .fire      (fire),
        .nibble    (tx_nibble)
    );

    com_cc_tx u_tx (
        .clk       (clk),
        .rst       (rst),
        .fire      (fire),
        .nibble    (tx_nibble),
        .slot_take (slot_take),
        .tx_pins   (tx_pins)
    );

    // receive side
    com_cc_rx u_rx (
        .clk         (clk),
        .rst         (rst),
        .rx_pins     (rx_pins),
        .nib_valid   (nib_valid),
        .nib         (rx_nib),
        .burst_start (burst_start)
    );

    com_cc_rx_pair u_rx_pair (
        .clk         (clk),
        .rst         (rst),
        .nib_valid   (nib_valid),
        .nib         (rx_nib),
        .burst_start (burst_start),
        .rx_valid    (rx_valid),
        .rx_byte     (rx_byte)
    );

endmodule

// ==== tb_com_cc.sv ====
`timescale 1ns/1ps

module tb_com_cc
    import com_cc_pkg::*;
;

    logic       clk;
    logic       rst;
    logic       wr;
    logic [7:0] wr_data;
    logic       full;
    lane_bus_t  pins;
    logic       rx_valid;
    rx_byte_t   rx_byte;

    // write and gap records in file order
    logic [7:0] rec_kind [$];
    int         rec_test [$];
    int         rec_a [$];
    int         rec_b [$];

    // expected bytes in arrival order
    rx_byte_t   exp_q [$];
    int         exp_test [$];

    int         cycle_limit;
    int         rx_count;
    int         byte_errors;
    int         stray_bytes;
    int         full_errors;
    int         pin_errors;
    int         trace_errors;
    rx_byte_t   next_exp;
    int         next_test;

    // transmit pins loop straight back into the receiver
    com_cc_link dut0 (
        .clk      (clk),
        .rst      (rst),
        .wr       (wr),
        .wr_data  (wr_data),
        .full     (full),
        .tx_pins  (pins),
        .rx_pins  (pins),
        .rx_valid (rx_valid),
        .rx_byte  (rx_byte)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic string test_name(input int t);
        case (t)
            1:       return "single_byte";
            2:       return "lane_patterns";
            3:       return "fill_queue";
            4:       return "write_while_full";
            5:       return "two_bursts";
            default: return "unknown";
        endcase
    endfunction

    task automatic check_byte(input string name, input rx_byte_t expected, input rx_byte_t actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected data %02h first %0b, actual data %02h first %0b",
                     name, expected.data, expected.first, actual.data, actual.first);
            byte_errors++;
        end
    endtask

    task automatic check_full(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected full %0b, actual full %0b", name, expected, actual);
            full_errors++;
        end
    endtask

    task automatic check_pins(input string name, input lane_bus_t expected,
                              input lane_bus_t actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected send %0b txd %04b, actual send %0b txd %04b",
                     name, expected.send, expected.txd, actual.send, actual.txd);
            pin_errors++;
        end
    endtask

    task automatic load_trace();
        int         fd;
        int         n;
        int         t;
        int         a;
        int         b;
        string      line;
        string      rest;
        logic [7:0] kind;
        rx_byte_t   want;
        cycle_limit = 0;
        fd = $fopen("com_cc_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open com_cc_trace.txt");
            trace_errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            kind = line.getc(0);
            rest = line.substr(1, line.len() - 1);
            b    = 0;
            if (kind == "G") begin
                n = $sscanf(rest, "%d %d", t, a) + 1;
            end else begin
                n = $sscanf(rest, "%d %h %d", t, a, b);
            end
            if (n != 3 || !(kind inside {"W", "G", "E"})) begin
                $display("trace line not understood: %s", line);
                trace_errors++;
            end else if (kind == "E") begin
                want.data  = 8'(a);
                want.first = (b != 0);
                exp_q.push_back(want);
                exp_test.push_back(t);
            end else begin
                rec_kind.push_back(kind);
                rec_test.push_back(t);
                rec_a.push_back(a);
                rec_b.push_back(b);
                // runaway limit grows with the trace
                cycle_limit += (kind == "W") ? 40 : a;
            end
        end
        $fclose(fd);
    endtask

    task automatic finish_run(input logic timed_out);
        $display(
            "errors: byte %0d full %0d pins %0d stray %0d trace %0d timeout %0b rx %0d",
            byte_errors, full_errors, pin_errors, stray_bytes, trace_errors, timed_out,
            rx_count);
        if (!timed_out && byte_errors == 0 && full_errors == 0 && pin_errors == 0
            && stray_bytes == 0 && trace_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    // each received byte is matched against the oldest expected one
    always @(negedge clk) begin
        if (!rst && rx_valid) begin
            if (exp_q.size() == 0) begin
                $display("received byte %02h while no byte was expected", rx_byte.data);
                stray_bytes++;
            end else begin
                next_exp  = exp_q.pop_front();
                next_test = exp_test.pop_front();
                check_byte($sformatf("%s rx %0d", test_name(next_test), rx_count),
                           next_exp, rx_byte);
                rx_count++;
            end
        end
    end

    initial begin : watchdog
        int cycle_cnt;
        cycle_cnt = 0;
        @(negedge rst);
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, %0d expected bytes never arrived",
                 cycle_cnt, exp_q.size());
        finish_run(1'b1);
    end

    initial begin : stimulus
        int i;
        rst          = 1'b1;
        wr           = 1'b0;
        wr_data      = '0;
        rx_count     = 0;
        byte_errors  = 0;
        stray_bytes  = 0;
        full_errors  = 0;
        pin_errors   = 0;
        trace_errors = 0;
        load_trace();
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;
        // pins rest low with nothing queued
        check_pins("after_reset", '0, pins);
        for (i = 0; i < rec_kind.size(); i++) begin
            if (rec_kind[i] == "W") begin
                // full as the queue sees it at the coming edge
                check_full($sformatf("%s write %0d", test_name(rec_test[i]), i),
                           rec_b[i] != 0, full);
                wr      = 1'b1;
                wr_data = 8'(rec_a[i]);
                @(posedge clk);
                #1;
                wr = 1'b0;
            end else if (rec_a[i] > 0) begin
                repeat (rec_a[i]) @(posedge clk);
                #1;
            end
        end
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        // room for a stray byte to show up
        repeat (40) @(posedge clk);
        #1;
        check_pins("end_idle", '0, pins);
        finish_run(1'b0);
    end

endmodule

// ==== com_cc_trace.txt ====
# W <test> <data hex> <full expected before the write>   G <test> <idle cycles>
# E <test> <data hex> <first flag>, expected bytes in arrival order
# single byte
W 1 a5 0
G 1 40
E 1 a5 1
# all-hold and all-toggle symbols back to back
W 2 00 0
W 2 ff 0
W 2 0f 0
W 2 f0 0
G 2 60
E 2 00 1
E 2 ff 0
E 2 0f 0
E 2 f0 0
# one byte leaves while these go in, so nine writes fill the queue
W 3 11 0
W 3 22 0
W 3 33 0
W 3 44 0
W 3 55 0
W 3 66 0
W 3 77 0
W 3 88 0
W 3 99 0
# this write is dropped, the next one lands after a byte leaves
W 4 ee 1
G 4 5
W 4 4b 0
G 4 100
E 3 11 1
E 3 22 0
E 3 33 0
E 3 44 0
E 3 55 0
E 3 66 0
E 3 77 0
E 3 88 0
E 3 99 0
E 4 4b 0
# two bursts with send low in between
W 5 3c 0
W 5 c3 0
G 5 50
W 5 5a 0
W 5 96 0
G 5 50
E 5 3c 1
E 5 c3 0
E 5 5a 1
E 5 96 0

// ==== compile.f ====
com_cc_pkg.sv
com_cc_tx_queue.sv
com_cc_tx.sv
com_cc_rx.sv
com_cc_rx_pair.sv
com_cc_link.sv
tb_com_cc.sv

// ==== Makefile ====
TOP = tb_com_cc

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir
